//--- cpu_core.f
src/cpu_types_pkg.sv
src/register_file.sv
src/instr_fetch_decode.sv
src/alu_execute.sv
src/result_writeback.sv
src/cpu_core.sv
test/cpu_core_sva.sv
test/cpu_core_checker.sv
test/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  # rtl, package first
  - src/cpu_types_pkg.sv
  - src/register_file.sv
  - src/instr_fetch_decode.sv
  - src/alu_execute.sv
  - src/result_writeback.sv
  - src/cpu_core.sv
  # testbench
  - target: test
    files:
      - test/cpu_core_sva.sv
      - test/cpu_core_checker.sv
      - test/cpu_core_tb.sv

//--- test/cpu_core_tb.sv
`timescale 1ns/10ps
// testbench for the core
// random programs from an LFSR, instruction and data memories with random
// wait states, a reference checker and a watchdog
module cpu_core_tb;

  localparam int NPROG         = 8;
  localparam int PROG_LEN      = 64;
  localparam int CYC_PER_INSTR = 8;
  localparam cpu_types_pkg::word_t PC_START = '0;

  logic                    CLK;
  logic                    nRST;
  logic                    ihit;
  logic                    dhit;
  cpu_types_pkg::word_t    imemload;
  cpu_types_pkg::word_t    dmemload;
  cpu_types_pkg::word_t    imemaddr;
  logic                    imemREN;
  cpu_types_pkg::mem_req_t dmem;
  logic                    halt;

  logic [31:0]             lfsr;
  cpu_types_pkg::word_t    imem [256];
  cpu_types_pkg::word_t    data_mem [256];
  int                      icnt;
  int                      dcnt;
  int                      pass_cnt;
  int                      fail_cnt;

  cpu_core #(.PC_INIT(PC_START)) dut_i (
    .CLK, .nRST, .imemload, .ihit, .dmemload, .dhit, .imemaddr, .imemREN, .dmem, .halt
  );

  cpu_core_checker #(.PC_INIT(PC_START)) checker_i (
    .CLK, .nRST, .imemaddr, .imemREN, .dmem, .dhit, .halt
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // ---------------------------------------------------------------------------
  // random source with taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic cpu_types_pkg::word_t enc_r(cpu_types_pkg::funct_t f,
      cpu_types_pkg::regsel_t rs, cpu_types_pkg::regsel_t rt, cpu_types_pkg::regsel_t rd,
      logic [4:0] sh);
    return {6'b000000, rs, rt, rd, sh, 6'(f)};
  endfunction

  function automatic cpu_types_pkg::word_t enc_i(cpu_types_pkg::opcode_t op,
      cpu_types_pkg::regsel_t rs, cpu_types_pkg::regsel_t rt, cpu_types_pkg::imm16_t imm);
    return {6'(op), rs, rt, imm};
  endfunction

  // error total over the checker and the bound assertions
  function automatic int error_total();
    return checker_i.errors + dut_i.sva_i.errors;
  endfunction

  // ---------------------------------------------------------------------------
  // program generator
  // kinds 13 and 14 become branches and jumps once all jal blocks are placed
  task automatic build_program();
    int                     kind [64];
    bit                     noland [64];
    int                     i;
    int                     t;
    logic [3:0]             sel;
    cpu_types_pkg::regsel_t a, b, c;
    for (int k = 0; k < 256; k++) imem[k] = '0;
    for (int k = 0; k < 64; k++) begin
      noland[k] = 0;
      kind[k]   = -1;
    end
    i = 0;
    while (i < PROG_LEN - 1) begin
      sel = 4'(rand_bits(4));
      a   = 5'(rand_bits(3));
      b   = 5'(rand_bits(3));
      c   = 5'(rand_bits(3));
      if (sel == 4'd15 && i <= PROG_LEN - 5) begin
        // jal into a body that returns through jr and a jump past the body
        imem[i]     = {6'(cpu_types_pkg::JAL), 26'(i + 2)};
        imem[i + 1] = {6'(cpu_types_pkg::J), 26'(i + 4)};
        imem[i + 2] = enc_r(cpu_types_pkg::ADDU, a, b, c, 5'd0);
        imem[i + 3] = enc_r(cpu_types_pkg::JR, 5'd31, 5'd0, 5'd0, 5'd0);
        noland[i + 2] = 1;
        noland[i + 3] = 1;
        i += 4;
      end else begin
        kind[i] = sel;
        case (sel)
          4'd0:  imem[i] = enc_r(cpu_types_pkg::ADDU, a, b, c, 5'd0);
          4'd1:  imem[i] = enc_r(cpu_types_pkg::SUBU, a, b, c, 5'd0);
          4'd2:  imem[i] = enc_r(cpu_types_pkg::AND, a, b, c, 5'd0);
          4'd3:  imem[i] = enc_r(cpu_types_pkg::OR, a, b, c, 5'd0);
          4'd4:  imem[i] = enc_r(cpu_types_pkg::SLT, a, b, c, 5'd0);
          4'd5:  imem[i] = enc_r(cpu_types_pkg::SLL, 5'd0, b, c, 5'(rand_bits(5)));
          4'd7:  imem[i] = enc_i(next_bit() ? cpu_types_pkg::ANDI : cpu_types_pkg::ORI,
                                 a, c, 16'(rand_bits(16)));
          4'd8:  imem[i] = enc_i(cpu_types_pkg::SLTI, a, c, 16'(rand_bits(16)));
          4'd9:  imem[i] = enc_i(cpu_types_pkg::LUI, 5'd0, c, 16'(rand_bits(16)));
          // base r0 and word offsets inside the data memory
          4'd10: imem[i] = enc_i(cpu_types_pkg::LW, 5'd0, c,
                                 16'({8'(rand_bits(8)), 2'b00}));
          4'd11, 4'd12: imem[i] = enc_i(cpu_types_pkg::SW, 5'd0, b,
                                        16'({8'(rand_bits(8)), 2'b00}));
          4'd13, 4'd14: imem[i] = '0;
          default: imem[i] = enc_i(cpu_types_pkg::ADDIU, a, c, 16'(rand_bits(16)));
        endcase
        i++;
      end
    end
    imem[PROG_LEN - 1] = {6'(cpu_types_pkg::HALT), 26'd0};
    // forward targets only and never into a jal body
    for (int k = 0; k < PROG_LEN - 1; k++) begin
      if (kind[k] == 13 || kind[k] == 14) begin
        t = k + 1 + int'(rand_bits(2));
        if (t > PROG_LEN - 1) t = PROG_LEN - 1;
        while (noland[t]) t++;
        if (kind[k] == 14) begin
          imem[k] = {6'(cpu_types_pkg::J), 26'(t)};
        end else begin
          imem[k] = enc_i(next_bit() ? cpu_types_pkg::BEQ : cpu_types_pkg::BNE,
                          5'(rand_bits(3)), 5'(rand_bits(3)), 16'(t - k - 1));
        end
      end
    end
    for (int k = 0; k < 256; k++) checker_i.prog[k] = imem[k];
  endtask

  // ---------------------------------------------------------------------------
  // memory models sample reset at the edge and drive 10 ns after it
  always @(posedge CLK) begin
    logic run;
    run = nRST;
    if (run && dmem.dmemWEN && dhit) data_mem[dmem.dmemaddr[9:2]] = dmem.dmemstore;
    #10;
    imemload = imem[imemaddr[9:2]];
    dmemload = data_mem[dmem.dmemaddr[9:2]];
    ihit     = 1'b0;
    dhit     = 1'b0;
    if (run && imemREN) begin
      if (icnt == 0) begin
        ihit = 1'b1;
        icnt = int'(rand_bits(2));
      end else begin
        icnt--;
      end
    end
    if (run && (dmem.dmemREN || dmem.dmemWEN)) begin
      if (dcnt == 0) begin
        dhit = 1'b1;
        dcnt = int'(rand_bits(2));
      end else begin
        dcnt--;
      end
    end
  end

  // one program from its own reset to halt
  task automatic run_program(input int p);
    int errs0;
    int n;
    bit ok;
    @(posedge CLK);
    #10;
    nRST = 1'b0;
    // program and memories loaded on the next edge inside reset
    @(posedge CLK);
    build_program();
    // data memory fill mixed from the whole word index
    for (int k = 0; k < 256; k++) begin
      data_mem[k]          = (32'(k) * 32'h9E3779B1) ^ {24'h5A5A5A, 8'(k)};
      checker_i.ref_mem[k] = data_mem[k];
    end
    checker_i.run_model();
    repeat (15) @(posedge CLK);
    #10;
    nRST  = 1'b1;
    errs0 = error_total();
    n     = 0;
    while (!halt && n < PROG_LEN * CYC_PER_INSTR) begin
      @(posedge CLK);
      n++;
    end
    ok = halt;
    if (!ok) $display("program %0d: halt not reached within %0d cycles", p, n);
    // halt must hold with no late store
    repeat (4) @(posedge CLK);
    checker_i.final_check();
    if (ok && error_total() == errs0) begin
      pass_cnt++;
      $display("program %0d: passed after %0d cycles", p, n);
    end else begin
      fail_cnt++;
      $display("program %0d: failed", p);
    end
  endtask

  initial begin
    nRST     = 1'b0;
    ihit     = 1'b0;
    dhit     = 1'b0;
    imemload = '0;
    dmemload = '0;
    lfsr     = 32'd85284;
    icnt     = 0;
    dcnt     = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    for (int p = 0; p < NPROG; p++) run_program(p);
    $display("programs passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog sized from program length and reset per program
  initial begin
    #(NPROG * (PROG_LEN * CYC_PER_INSTR + 40) * 100);
    $display("watchdog expired before all programs finished");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- test/cpu_core_checker.sv
`timescale 1ns/10ps
// reference model and store checker
// runs the program on an instruction-set model, then compares the reset
// state, every completed DUT store and the halt bit against it
module cpu_core_checker #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input logic                    CLK,
  input logic                    nRST,
  input cpu_types_pkg::word_t    imemaddr,
  input logic                    imemREN,
  input cpu_types_pkg::mem_req_t dmem,
  input logic                    dhit,
  input logic                    halt
);

  cpu_types_pkg::word_t prog [256];
  cpu_types_pkg::word_t ref_mem [256];
  // expected store stream, in program order
  cpu_types_pkg::word_t exp_addr [$];
  cpu_types_pkg::word_t exp_data [$];
  int                   errors = 0;
  logic                 halt_q = 1'b0;
  logic                 rst_q = 1'b0;

  // ---------------------------------------------------------------------------
  // instruction-set model without delay slots
  task automatic run_model();
    cpu_types_pkg::word_t r [32];
    cpu_types_pkg::word_t pc, npc, ins, simm, zimm, ea;
    logic [4:0]           rs, rt, rd;
    int                   steps;
    bit                   done;
    for (int k = 0; k < 32; k++) r[k] = '0;
    exp_addr.delete();
    exp_data.delete();
    pc    = PC_INIT;
    steps = 0;
    done  = 0;
    while (!done && steps < 4096) begin
      ins  = prog[pc[9:2]];
      npc  = pc + 32'd4;
      rs   = ins[25:21];
      rt   = ins[20:16];
      rd   = ins[15:11];
      simm = {{16{ins[15]}}, ins[15:0]};
      zimm = {16'h0000, ins[15:0]};
      ea   = r[rs] + simm;
      case (ins[31:26])
        cpu_types_pkg::RTYPE: begin
          case (ins[5:0])
            cpu_types_pkg::ADDU: r[rd] = r[rs] + r[rt];
            cpu_types_pkg::SUBU: r[rd] = r[rs] - r[rt];
            cpu_types_pkg::AND:  r[rd] = r[rs] & r[rt];
            cpu_types_pkg::OR:   r[rd] = r[rs] | r[rt];
            cpu_types_pkg::SLT:  r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
            cpu_types_pkg::SLL:  r[rd] = r[rt] << ins[10:6];
            cpu_types_pkg::JR:   npc = r[rs];
            default: ;
          endcase
        end
        cpu_types_pkg::ADDIU: r[rt] = r[rs] + simm;
        cpu_types_pkg::SLTI:  r[rt] = ($signed(r[rs]) < $signed(simm)) ? 32'd1 : 32'd0;
        cpu_types_pkg::ANDI:  r[rt] = r[rs] & zimm;
        cpu_types_pkg::ORI:   r[rt] = r[rs] | zimm;
        cpu_types_pkg::LUI:   r[rt] = {ins[15:0], 16'h0000};
        cpu_types_pkg::LW:    r[rt] = ref_mem[ea[9:2]];
        cpu_types_pkg::SW: begin
          exp_addr.push_back(ea);
          exp_data.push_back(r[rt]);
          ref_mem[ea[9:2]] = r[rt];
        end
        cpu_types_pkg::BEQ:   if (r[rs] == r[rt]) npc = pc + 32'd4 + (simm << 2);
        cpu_types_pkg::BNE:   if (r[rs] != r[rt]) npc = pc + 32'd4 + (simm << 2);
        cpu_types_pkg::J:     npc = {npc[31:28], ins[25:0], 2'b00};
        cpu_types_pkg::JAL: begin
          r[31] = pc + 32'd4;
          npc   = {npc[31:28], ins[25:0], 2'b00};
        end
        cpu_types_pkg::HALT:  done = 1;
        default: ;
      endcase
      r[0] = '0;
      pc   = npc;
      steps++;
    end
  endtask

  // every model store must have shown up by now
  task automatic final_check();
    if (exp_addr.size() != 0) begin
      $display("Fail %0t: %0d expected stores missing", $time, exp_addr.size());
      errors++;
    end
  endtask

  // ---------------------------------------------------------------------------
  // store and halt watch
  always @(posedge CLK) begin
    cpu_types_pkg::word_t ea;
    cpu_types_pkg::word_t ed;
    if (nRST) begin
      // first edge out of reset still shows the reset state
      if (!rst_q && (imemaddr !== PC_INIT || imemREN !== 1'b1 || halt !== 1'b0
                     || dmem.dmemREN !== 1'b0 || dmem.dmemWEN !== 1'b0)) begin
        $display("Fail %0t: reset state pc %h imemREN %b halt %b dmem %b%b", $time,
                 imemaddr, imemREN, halt, dmem.dmemREN, dmem.dmemWEN);
        errors++;
      end
      if (halt_q && !halt) begin
        $display("Fail %0t: halt fell before reset", $time);
        errors++;
      end
      if (dmem.dmemWEN && dhit) begin
        if (exp_addr.size() == 0) begin
          $display("Fail %0t: unexpected store %h to %h", $time, dmem.dmemstore,
                   dmem.dmemaddr);
          errors++;
        end else begin
          ea = exp_addr.pop_front();
          ed = exp_data.pop_front();
          if (ea != dmem.dmemaddr || ed != dmem.dmemstore) begin
            $display("Fail %0t: store %h to %h, expected %h to %h", $time,
                     dmem.dmemstore, dmem.dmemaddr, ed, ea);
            errors++;
          end
        end
      end
    end
    halt_q = nRST && halt;
    rst_q  = nRST;
  end

endmodule

//--- test/cpu_core_sva.sv
`timescale 1ns/10ps
// port assertions for the core
// data port request rules and halt behaviour, bound into cpu_core
module cpu_core_sva (
  input logic                    CLK,
  input logic                    nRST,
  input cpu_types_pkg::mem_req_t dmem,
  input logic                    dhit,
  input logic                    halt,
  input logic                    imemREN
);

  // assertion failures so far
  int errors = 0;

  // one data access kind at a time
  a_rd_wr_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem.dmemREN && dmem.dmemWEN))
    else begin
      $error("dmemREN and dmemWEN high together");
      errors++;
    end

  // pending request holds until dhit
  a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (dmem.dmemREN || dmem.dmemWEN) && !dhit |=> $stable(dmem))
    else begin
      $error("data request changed while waiting for dhit");
      errors++;
    end

  // halt is sticky
  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt)
    else begin
      $error("halt fell before reset");
      errors++;
    end

  a_no_fetch_halted: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !imemREN)
    else begin
      $error("imemREN high while halted");
      errors++;
    end

endmodule

bind cpu_core cpu_core_sva sva_i (
  .CLK(CLK), .nRST(nRST), .dmem(dmem), .dhit(dhit), .halt(halt), .imemREN(imemREN)
);

//--- src/cpu_core.sv
`timescale 1ns/10ps
// cpu core top
// four-stage MIPS subset pipeline, fetch/decode, execute and result,
// around a write-through register file with plain level memory ports
module cpu_core #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::word_t    imemload,
  input  logic                    ihit,
  input  cpu_types_pkg::word_t    dmemload,
  input  logic                    dhit,
  output cpu_types_pkg::word_t    imemaddr,
  output logic                    imemREN,
  output cpu_types_pkg::mem_req_t dmem,
  output logic                    halt
);

  // stage registers
  cpu_types_pkg::decode_exec_t de_reg;
  cpu_types_pkg::exec_result_t er_reg;
  // control flow back to fetch
  logic                        redirect;
  cpu_types_pkg::word_t        redirect_pc;
  logic                        freeze;
  // register file ports
  cpu_types_pkg::regsel_t      rsel1;
  cpu_types_pkg::regsel_t      rsel2;
  cpu_types_pkg::word_t        rdat1;
  cpu_types_pkg::word_t        rdat2;
  logic                        wen;
  cpu_types_pkg::regsel_t      wsel;
  cpu_types_pkg::word_t        wdat;

  instr_fetch_decode #(.PC_INIT(PC_INIT)) fetch_decode_i (
    .CLK, .nRST, .imemload, .ihit, .imemaddr, .imemREN,
    .freeze, .halt, .redirect, .redirect_pc,
    .rsel1, .rsel2, .rdat1, .rdat2, .de_reg
  );

  register_file regfile_i (
    .CLK, .nRST, .wen, .wsel, .wdat, .rsel1, .rsel2, .rdat1, .rdat2
  );

  alu_execute execute_i (
    .CLK, .nRST, .freeze, .de_reg, .er_reg, .redirect, .redirect_pc
  );

  result_writeback result_i (
    .CLK, .nRST, .er_reg, .dmemload, .dhit, .dmem,
    .wen, .wsel, .wdat, .freeze, .halt
  );

endmodule

//--- src/result_writeback.sv
`timescale 1ns/10ps
// result stage
// issues data port requests, selects the write-back value, raises freeze
// on a pending data access and holds the sticky halt bit
module result_writeback (
  input  logic                        CLK,
  input  logic                        nRST,
  input  cpu_types_pkg::exec_result_t er_reg,
  input  cpu_types_pkg::word_t        dmemload,
  input  logic                        dhit,
  output cpu_types_pkg::mem_req_t     dmem,
  output logic                        wen,
  output cpu_types_pkg::regsel_t      wsel,
  output cpu_types_pkg::word_t        wdat,
  output logic                        freeze,
  output logic                        halt
);

  logic live;
  logic mem_op;
  logic done;

  // nothing in the result stage acts once halted
  assign live   = er_reg.valid && !halt;
  assign mem_op = er_reg.mem_rd || er_reg.mem_wr;
  // retire on dhit for memory ops, at once otherwise
  assign done   = live && (!mem_op || dhit);

  always_comb begin
    dmem.dmemREN   = live && er_reg.mem_rd;
    dmem.dmemWEN   = live && er_reg.mem_wr;
    dmem.dmemaddr  = er_reg.mem_addr;
    dmem.dmemstore = er_reg.store_data;
  end

  // register write
  assign wen  = done && er_reg.reg_wr;
  assign wsel = er_reg.wsel;
  assign wdat = er_reg.mem_rd ? dmemload : er_reg.value;

  // whole pipe holds on a waiting access or after halt
  assign freeze = halt || (live && mem_op && !dhit);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (done && er_reg.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

//--- src/alu_execute.sv
`timescale 1ns/10ps
// execute stage
// forwards from the result stage, runs the ALU, resolves every branch and
// jump, and registers the outcome for the result stage
module alu_execute (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        freeze,
  input  cpu_types_pkg::decode_exec_t de_reg,
  output cpu_types_pkg::exec_result_t er_reg,
  output logic                        redirect,
  output cpu_types_pkg::word_t        redirect_pc
);

  logic                        fwd_ok;
  cpu_types_pkg::word_t        opa;
  cpu_types_pkg::word_t        opb;
  cpu_types_pkg::word_t        alu_b;
  cpu_types_pkg::word_t        alu_out;
  logic                        br_taken;
  cpu_types_pkg::word_t        br_target;
  cpu_types_pkg::word_t        j_target;
  cpu_types_pkg::exec_result_t er_next;

  // -------------------------------------------------------------------------
  // forwarding, loads never forward here
  assign fwd_ok = er_reg.valid && er_reg.reg_wr && !er_reg.mem_rd && er_reg.wsel != '0;
  assign opa    = (fwd_ok && er_reg.wsel == de_reg.rs) ? er_reg.value : de_reg.rdat1;
  assign opb    = (fwd_ok && er_reg.wsel == de_reg.rt) ? er_reg.value : de_reg.rdat2;
  assign alu_b  = de_reg.alu_src ? de_reg.imm : opb;

  // alu
  always_comb begin
    case (de_reg.aluop)
      cpu_types_pkg::ALU_SUB: alu_out = opa - alu_b;
      cpu_types_pkg::ALU_AND: alu_out = opa & alu_b;
      cpu_types_pkg::ALU_OR:  alu_out = opa | alu_b;
      cpu_types_pkg::ALU_SLT: alu_out = {31'b0, $signed(opa) < $signed(alu_b)};
      // rt shifted by shamt
      cpu_types_pkg::ALU_SLL: alu_out = alu_b << de_reg.instr[10:6];
      default:                alu_out = opa + alu_b;
    endcase
  end

  // -------------------------------------------------------------------------
  // branch and jump resolution
  assign br_taken  = (de_reg.is_beq && opa == opb) || (de_reg.is_bne && opa != opb);
  assign br_target = de_reg.pc_plus4 + {de_reg.imm[29:0], 2'b00};
  assign j_target  = {de_reg.pc_plus4[31:28], de_reg.instr[25:0], 2'b00};
  assign redirect  = de_reg.valid
                     && (br_taken || de_reg.is_j || de_reg.is_jal || de_reg.is_jr);

  always_comb begin
    if (de_reg.is_jr) begin
      redirect_pc = opa;
    end else if (de_reg.is_j || de_reg.is_jal) begin
      redirect_pc = j_target;
    end else begin
      redirect_pc = br_target;
    end
  end

  // next result register, value is the final non-load write
  always_comb begin
    er_next            = '0;
    er_next.valid      = de_reg.valid;
    er_next.wsel       = de_reg.wsel;
    er_next.reg_wr     = de_reg.reg_wr;
    er_next.mem_rd     = de_reg.mem_rd;
    er_next.mem_wr     = de_reg.mem_wr;
    er_next.halt       = de_reg.halt;
    er_next.store_data = opb;
    er_next.mem_addr   = alu_out;
    if (de_reg.is_lui) begin
      er_next.value = {de_reg.imm[15:0], 16'h0000};
    end else if (de_reg.is_jal) begin
      er_next.value = de_reg.pc_plus4;
    end else begin
      er_next.value = alu_out;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      er_reg <= '0;
    end else if (!freeze) begin
      er_reg <= er_next;
    end
  end

endmodule

//--- src/instr_fetch_decode.sv
`timescale 1ns/10ps
// fetch and decode stages
// holds the program counter and fetch register, decodes the fetched word
// into control fields and registers it for execute, stalls on load-use
module instr_fetch_decode #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                        CLK,
  input  logic                        nRST,
  input  cpu_types_pkg::word_t        imemload,
  input  logic                        ihit,
  output cpu_types_pkg::word_t        imemaddr,
  output logic                        imemREN,
  input  logic                        freeze,
  input  logic                        halt,
  input  logic                        redirect,
  input  cpu_types_pkg::word_t        redirect_pc,
  output cpu_types_pkg::regsel_t      rsel1,
  output cpu_types_pkg::regsel_t      rsel2,
  input  cpu_types_pkg::word_t        rdat1,
  input  cpu_types_pkg::word_t        rdat2,
  output cpu_types_pkg::decode_exec_t de_reg
);

  cpu_types_pkg::word_t        pc;
  logic                        fetched;
  logic                        fd_valid;
  cpu_types_pkg::word_t        fd_instr;
  cpu_types_pkg::word_t        fd_pc_plus4;
  cpu_types_pkg::opcode_t      op;
  cpu_types_pkg::funct_t       fn;
  cpu_types_pkg::imm16_t       imm16;
  cpu_types_pkg::decode_exec_t de_next;
  logic                        load_stall;

  // -------------------------------------------------------------------------
  // fetch
  assign imemaddr = pc;
  assign imemREN  = ~halt;
  // word delivered this cycle
  assign fetched  = imemREN && ihit;

  // instruction fields
  assign op    = cpu_types_pkg::opcode_t'(fd_instr[31:26]);
  assign fn    = cpu_types_pkg::funct_t'(fd_instr[5:0]);
  assign imm16 = fd_instr[15:0];
  assign rsel1 = fd_instr[25:21];
  assign rsel2 = fd_instr[20:16];

  // -------------------------------------------------------------------------
  // control decode
  always_comb begin
    de_next          = '0;
    de_next.valid    = fd_valid;
    de_next.pc_plus4 = fd_pc_plus4;
    de_next.instr    = fd_instr;
    de_next.rs       = rsel1;
    de_next.rt       = rsel2;
    de_next.rdat1    = rdat1;
    de_next.rdat2    = rdat2;
    // sign extension unless a logical immediate
    de_next.imm      = {{16{imm16[15]}}, imm16};
    de_next.wsel     = rsel2;
    de_next.aluop    = cpu_types_pkg::ALU_ADD;
    case (op)
      cpu_types_pkg::RTYPE: begin
        de_next.wsel   = fd_instr[15:11];
        de_next.reg_wr = 1'b1;
        case (fn)
          cpu_types_pkg::ADDU: de_next.aluop = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: de_next.aluop = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  de_next.aluop = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   de_next.aluop = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::SLT:  de_next.aluop = cpu_types_pkg::ALU_SLT;
          cpu_types_pkg::SLL:  de_next.aluop = cpu_types_pkg::ALU_SLL;
          cpu_types_pkg::JR: begin
            de_next.is_jr  = 1'b1;
            de_next.reg_wr = 1'b0;
          end
          // unknown funct runs as a nop
          default: de_next.reg_wr = 1'b0;
        endcase
      end
      cpu_types_pkg::ADDIU: begin
        de_next.alu_src = 1'b1;
        de_next.reg_wr  = 1'b1;
      end
      cpu_types_pkg::SLTI: begin
        de_next.alu_src = 1'b1;
        de_next.reg_wr  = 1'b1;
        de_next.aluop   = cpu_types_pkg::ALU_SLT;
      end
      cpu_types_pkg::ANDI: begin
        de_next.alu_src = 1'b1;
        de_next.reg_wr  = 1'b1;
        de_next.aluop   = cpu_types_pkg::ALU_AND;
        de_next.imm     = {16'h0000, imm16};
      end
      cpu_types_pkg::ORI: begin
        de_next.alu_src = 1'b1;
        de_next.reg_wr  = 1'b1;
        de_next.aluop   = cpu_types_pkg::ALU_OR;
        de_next.imm     = {16'h0000, imm16};
      end
      cpu_types_pkg::LUI: begin
        de_next.reg_wr = 1'b1;
        de_next.is_lui = 1'b1;
      end
      cpu_types_pkg::LW: begin
        de_next.alu_src = 1'b1;
        de_next.reg_wr  = 1'b1;
        de_next.mem_rd  = 1'b1;
      end
      cpu_types_pkg::SW: begin
        de_next.alu_src = 1'b1;
        de_next.mem_wr  = 1'b1;
      end
      cpu_types_pkg::BEQ:  de_next.is_beq = 1'b1;
      cpu_types_pkg::BNE:  de_next.is_bne = 1'b1;
      cpu_types_pkg::J:    de_next.is_j = 1'b1;
      cpu_types_pkg::JAL: begin
        de_next.is_jal = 1'b1;
        de_next.reg_wr = 1'b1;
        // link register
        de_next.wsel   = 5'd31;
      end
      cpu_types_pkg::HALT: de_next.halt = 1'b1;
      default: ;
    endcase
  end

  // load in execute feeding the word in decode
  assign load_stall = fd_valid && de_reg.valid && de_reg.mem_rd && de_reg.wsel != '0
                      && (de_reg.wsel == rsel1 || de_reg.wsel == rsel2);

  // -------------------------------------------------------------------------
  // pc, fetch register, decode register
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc          <= PC_INIT;
      fd_valid    <= 1'b0;
      fd_instr    <= '0;
      fd_pc_plus4 <= '0;
      de_reg      <= '0;
    end else if (!freeze) begin
      if (redirect) begin
        // squash both younger slots
        pc       <= redirect_pc;
        fd_valid <= 1'b0;
        de_reg   <= '0;
      end else if (load_stall) begin
        // hold pc and fetch reg, bubble into execute
        de_reg <= '0;
      end else begin
        de_reg   <= de_next;
        fd_valid <= fetched;
        if (fetched) begin
          pc          <= pc + 32'd4;
          fd_instr    <= imemload;
          fd_pc_plus4 <= pc + 32'd4;
        end
      end
    end
  end

endmodule

//--- src/register_file.sv
`timescale 1ns/10ps
// register file
// 31 general registers, two read ports and one write port
// a write in the same cycle is passed straight to the read ports
module register_file (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   wen,
  input  cpu_types_pkg::regsel_t wsel,
  input  cpu_types_pkg::word_t   wdat,
  input  cpu_types_pkg::regsel_t rsel1,
  input  cpu_types_pkg::regsel_t rsel2,
  output cpu_types_pkg::word_t   rdat1,
  output cpu_types_pkg::word_t   rdat2
);

  // no storage behind register 0
  cpu_types_pkg::word_t regs [31:1];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // read with write-through, r0 stays zero
  always_comb begin
    rdat1 = '0;
    rdat2 = '0;
    if (rsel1 != '0) begin
      rdat1 = (wen && wsel == rsel1) ? wdat : regs[rsel1];
    end
    if (rsel2 != '0) begin
      rdat2 = (wen && wsel == rsel2) ? wdat : regs[rsel2];
    end
  end

endmodule

//--- src/cpu_types_pkg.sv
// cpu types
// word types, instruction encodings and the pipeline register layouts
// shared by every stage of the four-stage MIPS subset core
package cpu_types_pkg;

  // -------------------------------------------------------------------------
  // widths with a meaning
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regsel_t;
  typedef logic [15:0] imm16_t;

  // -------------------------------------------------------------------------
  // instruction encodings
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  typedef enum logic [5:0] {
    SLL  = 6'b000000,
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL
  } aluop_t;

  // -------------------------------------------------------------------------
  // decode to execute register
  typedef struct packed {
    logic    valid;
    word_t   pc_plus4;
    word_t   instr;
    regsel_t rs;
    regsel_t rt;
    word_t   rdat1;
    word_t   rdat2;
    word_t   imm;
    regsel_t wsel;
    aluop_t  aluop;
    logic    alu_src;
    logic    reg_wr;
    logic    mem_rd;
    logic    mem_wr;
    logic    is_lui;
    logic    is_jal;
    logic    is_jr;
    logic    is_j;
    logic    is_beq;
    logic    is_bne;
    logic    halt;
  } decode_exec_t;

  // execute to result register
  typedef struct packed {
    logic    valid;
    regsel_t wsel;
    logic    reg_wr;
    logic    mem_rd;
    logic    mem_wr;
    logic    halt;
    // alu result, lui value or link address
    word_t   value;
    word_t   store_data;
    word_t   mem_addr;
  } exec_result_t;

  // data port outputs
  typedef struct packed {
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;
  } mem_req_t;

endpackage
